// File: hw/rv_pkg.sv
package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ADD is zero so a cleared payload is a harmless add
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        ctrl_t       ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        ctrl_t       ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] wb_data;
        logic [4:0]  rd;
        logic        reg_write;
    } mem_wb_t;

endpackage

// File: hw/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic [31:0]
) (
    input  logic clk,
    input  logic arst_n,
    input  logic hold,
    input  logic bubble,
    input  T     d,
    output T     q
);

    // All-zero payload has every control bit clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Write-through so ID sees the value retiring in WB
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [31:0]   instr,
    output logic [4:0]    rs1,
    output logic [4:0]    rs2,
    output logic [4:0]    rd,
    output logic [31:0]   imm,
    output rv_pkg::ctrl_t ctrl
);

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [31:0]     imm_i, imm_s, imm_b, imm_u;
    rv_pkg::alu_op_e f3_op;
    logic            use_rs1, use_rs2, valid;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};

    // Shared by the register and immediate forms
    always_comb begin
        case (funct3)
            3'b001:  f3_op = rv_pkg::ALU_SLL;
            3'b010:  f3_op = rv_pkg::ALU_SLT;
            3'b100:  f3_op = rv_pkg::ALU_XOR;
            3'b101:  f3_op = rv_pkg::ALU_SRL;
            3'b110:  f3_op = rv_pkg::ALU_OR;
            3'b111:  f3_op = rv_pkg::ALU_AND;
            default: f3_op = rv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl    = '0;
        imm     = imm_i;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        valid   = 1'b0;
        case (rv_pkg::opcode_e'(instr[6:0]))
            rv_pkg::OPC_OP: begin
                valid = funct3 != 3'b011 &&
                        (funct7 == 7'd0 || (funct7 == 7'b0100000 && funct3 == 3'b000));
                ctrl.alu_op    = funct7[5] ? rv_pkg::ALU_SUB : f3_op;
                ctrl.reg_write = 1'b1;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                // srai and sltiu fall outside the subset
                valid = funct3 != 3'b011 && (funct3[1:0] != 2'b01 || funct7 == 7'd0);
                ctrl.alu_op    = f3_op;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                use_rs1        = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                valid          = 1'b1;
                ctrl.alu_op    = rv_pkg::ALU_PASS_B;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            rv_pkg::OPC_LOAD: begin
                valid          = funct3 == 3'b010;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                use_rs1        = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                valid          = funct3 == 3'b010;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = imm_s;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                valid          = funct3[2:1] == 2'b00;
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm            = imm_b;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            default: ;
        endcase
        if (!valid) begin
            ctrl    = '0;
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
        end
    end

    // Unused fields read as x0 so they never trip the hazard logic
    assign rs1 = use_rs1 ? instr[19:15] : 5'd0;
    assign rs2 = use_rs2 ? instr[24:20] : 5'd0;
    assign rd  = ctrl.reg_write ? instr[11:7] : 5'd0;

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_e op,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  logic            branch_ne,
    output logic [31:0]     y,
    output logic            cond
);

    logic lt_signed;

    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:    y = a + b;
            rv_pkg::ALU_SUB:    y = a - b;
            rv_pkg::ALU_AND:    y = a & b;
            rv_pkg::ALU_OR:     y = a | b;
            rv_pkg::ALU_XOR:    y = a ^ b;
            rv_pkg::ALU_SLT:    y = {31'd0, lt_signed};
            // Shift amount is the low five bits only
            rv_pkg::ALU_SLL:    y = a << b[4:0];
            rv_pkg::ALU_SRL:    y = a >> b[4:0];
            rv_pkg::ALU_PASS_B: y = b;
            default:            y = 32'd0;
        endcase
    end

    // beq on equal, bne on different
    assign cond = branch_ne ? (a != b) : (a == b);

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0]       id_rs1,
    input  logic [4:0]       id_rs2,
    input  logic [4:0]       ex_rs1,
    input  logic [4:0]       ex_rs2,
    input  logic [4:0]       ex_rd,
    input  logic             ex_mem_read,
    input  logic [4:0]       mem_rd,
    input  logic             mem_reg_write,
    input  logic [4:0]       wb_rd,
    input  logic             wb_reg_write,
    input  logic             taken,
    input  logic             acki_n,
    input  logic             ackd_n,
    input  logic             mreq,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b,
    output logic             stall,
    output logic             flush,
    output logic             interlock
);

    logic load_use;

    // Youngest producer wins, x0 is never forwarded
    function automatic rv_pkg::fwd_sel_e pick_src(input logic [4:0] rs);
        if (rs != 5'd0 && mem_reg_write && mem_rd == rs) begin
            return rv_pkg::FWD_EX_MEM;
        end else if (rs != 5'd0 && wb_reg_write && wb_rd == rs) begin
            return rv_pkg::FWD_MEM_WB;
        end
        return rv_pkg::FWD_RF;
    endfunction

    always_comb begin
        fwd_a = pick_src(ex_rs1);
        fwd_b = pick_src(ex_rs2);
    end

    assign load_use = ex_mem_read && ex_rd != 5'd0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // A pending fetch or data access freezes the whole pipe
    assign interlock = acki_n | (mreq & ackd_n);

    assign stall = load_use & ~interlock;
    assign flush = taken & ~interlock;

endmodule

// File: hw/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic [31:0] iad,
    input  logic [31:0] idt,
    input  logic        acki_n,
    output logic [31:0] dad,
    output logic [31:0] dout,
    input  logic [31:0] din,
    output logic        mreq,
    output logic        write,
    input  logic        ackd_n
);

    logic [31:0]      pc, branch_target;
    rv_pkg::if_id_t   if_id_d, if_id_q;
    rv_pkg::id_ex_t   id_ex_d, id_ex_q;
    rv_pkg::ex_mem_t  ex_mem_d, ex_mem_q;
    rv_pkg::mem_wb_t  mem_wb_d, mem_wb_q;
    logic [4:0]       id_rs1, id_rs2, id_rd;
    logic [31:0]      id_imm, rf_rd1, rf_rd2;
    rv_pkg::ctrl_t    id_ctrl;
    rv_pkg::fwd_sel_e fwd_a, fwd_b;
    logic [31:0]      op_a, op_b_reg, alu_b, alu_y;
    logic             alu_cond, taken;
    logic             stall, flush, interlock;
    logic             dmem_done;
    logic [31:0]      load_data;

    function automatic logic [31:0] fwd_mux(input rv_pkg::fwd_sel_e sel,
                                            input logic [31:0] rf_val,
                                            input logic [31:0] ex_mem_val,
                                            input logic [31:0] mem_wb_val);
        case (sel)
            rv_pkg::FWD_EX_MEM: return ex_mem_val;
            rv_pkg::FWD_MEM_WB: return mem_wb_val;
            default:            return rf_val;
        endcase
    endfunction

    // Fetch
    assign branch_target = id_ex_q.pc + id_ex_q.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (!interlock && !stall) begin
            pc <= flush ? branch_target : pc + 32'd4;
        end
    end

    assign iad     = pc;
    assign if_id_d = '{pc: pc, instr: idt};

    pipe_reg #(.T(rv_pkg::if_id_t)) if_id_reg (
        .clk(clk), .arst_n(arst_n),
        .hold(interlock | stall), .bubble(flush),
        .d(if_id_d), .q(if_id_q)
    );

    // Decode
    decoder i_decoder (
        .instr(if_id_q.instr),
        .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd),
        .imm(id_imm), .ctrl(id_ctrl)
    );

    regfile i_regfile (
        .clk(clk), .arst_n(arst_n),
        .ra1(id_rs1), .ra2(id_rs2), .rd1(rf_rd1), .rd2(rf_rd2),
        .we(mem_wb_q.reg_write), .wa(mem_wb_q.rd), .wd(mem_wb_q.wb_data)
    );

    assign id_ex_d = '{pc: if_id_q.pc, rs1_val: rf_rd1, rs2_val: rf_rd2, imm: id_imm,
                       rs1: id_rs1, rs2: id_rs2, rd: id_rd, ctrl: id_ctrl};

    pipe_reg #(.T(rv_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .arst_n(arst_n),
        .hold(interlock), .bubble(stall | flush),
        .d(id_ex_d), .q(id_ex_q)
    );

    // Execute
    assign op_a     = fwd_mux(fwd_a, id_ex_q.rs1_val, ex_mem_q.result, mem_wb_q.wb_data);
    assign op_b_reg = fwd_mux(fwd_b, id_ex_q.rs2_val, ex_mem_q.result, mem_wb_q.wb_data);
    assign alu_b    = id_ex_q.ctrl.use_imm ? id_ex_q.imm : op_b_reg;

    alu i_alu (
        .op(id_ex_q.ctrl.alu_op), .a(op_a), .b(alu_b),
        .branch_ne(id_ex_q.ctrl.branch_ne), .y(alu_y), .cond(alu_cond)
    );

    assign taken    = id_ex_q.ctrl.branch & alu_cond;
    assign ex_mem_d = '{result: alu_y, store_data: op_b_reg, rd: id_ex_q.rd,
                        ctrl: id_ex_q.ctrl};

    pipe_reg #(.T(rv_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .arst_n(arst_n),
        .hold(interlock), .bubble(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // Memory. An access that finished during a fetch wait is not issued again
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dmem_done <= 1'b0;
        end else if (!interlock) begin
            dmem_done <= 1'b0;
        end else if (mreq && !ackd_n) begin
            dmem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mreq && !ackd_n) begin
            load_data <= din;
        end
    end

    assign mreq  = (ex_mem_q.ctrl.mem_read | ex_mem_q.ctrl.mem_write) & ~dmem_done;
    assign write = mreq & ex_mem_q.ctrl.mem_write;
    assign dad   = ex_mem_q.result;
    assign dout  = ex_mem_q.store_data;

    assign mem_wb_d.wb_data   = !ex_mem_q.ctrl.mem_read ? ex_mem_q.result :
                                dmem_done ? load_data : din;
    assign mem_wb_d.rd        = ex_mem_q.rd;
    assign mem_wb_d.reg_write = ex_mem_q.ctrl.reg_write;

    pipe_reg #(.T(rv_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .arst_n(arst_n),
        .hold(interlock), .bubble(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    hazard_unit i_hazard_unit (
        .id_rs1(id_rs1), .id_rs2(id_rs2),
        .ex_rs1(id_ex_q.rs1), .ex_rs2(id_ex_q.rs2), .ex_rd(id_ex_q.rd),
        .ex_mem_read(id_ex_q.ctrl.mem_read),
        .mem_rd(ex_mem_q.rd), .mem_reg_write(ex_mem_q.ctrl.reg_write),
        .wb_rd(mem_wb_q.rd), .wb_reg_write(mem_wb_q.reg_write),
        .taken(taken), .acki_n(acki_n), .ackd_n(ackd_n), .mreq(mreq),
        .fwd_a(fwd_a), .fwd_b(fwd_b),
        .stall(stall), .flush(flush), .interlock(interlock)
    );

endmodule

// File: sim/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam logic [31:0] SENTINEL = 32'h0000_03fc;

    logic        clk;
    logic        arst_n;
    logic [31:0] iad, idt, dad, dout, din;
    logic        acki_n, ackd_n, mreq, write;

    logic [31:0] imem [128];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [6:0]  prog_len;
    int          slot;
    int          exp_count, limit;
    int          i_wait, d_wait, i_draw, d_draw;
    logic        random_waits = 1'b0;
    logic        stop_run = 1'b0;
    int          cycles = 0;
    int          store_idx = 0;
    int          mismatches = 0;
    int          bus_errors = 0;
    int          run_errors = 0;
    logic        in_reset = 1'b0;
    logic        held_valid = 1'b0;
    logic [31:0] held_dad, held_dout;
    logic        held_write;

    core_top #(.RESET_PC(RESET_PC)) i_dut (
        .clk(clk), .arst_n(arst_n),
        .iad(iad), .idt(idt), .acki_n(acki_n),
        .dad(dad), .dout(dout), .din(din),
        .mreq(mreq), .write(write), .ackd_n(ackd_n)
    );

    always #20 clk = ~clk;

    // Both memories answer combinationally
    assign idt = imem[iad[8:2]];
    assign din = dmem[dad[9:2]];

    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int rd, input int imm);
        return {imm[19:0], rd[4:0], rv_pkg::OPC_LUI};
    endfunction

    task automatic emit(input logic [31:0] instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic store_result(input int rs);
        emit(s_type(rs, 0, slot));
        slot += 4;
    endtask

    task automatic load_program();
        prog_len = 7'd0;
        slot = 'h100;
        for (int i = 0; i < 128; i++) begin
            imem[i[6:0]] = 32'd0;
        end
        // Constants, stored at distance one and two
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 1, 0, 'h123));
        store_result(1);
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 2, 0, -5));
        emit(u_type(3, 'h80000));
        store_result(2);
        store_result(3);
        emit(r_type(0, 0, 4, 1, 2));
        emit(r_type('h20, 0, 5, 4, 1));
        store_result(4);
        store_result(5);
        emit(r_type(0, 7, 6, 5, 1));
        store_result(6);
        emit(r_type(0, 6, 7, 1, 3));
        store_result(7);
        emit(r_type(0, 4, 8, 7, 2));
        store_result(8);
        // slt both ways round with a negative operand
        emit(r_type(0, 2, 9, 2, 1));
        store_result(9);
        emit(r_type(0, 2, 10, 1, 2));
        store_result(10);
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 12, 0, 20));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 14, 0, 35));
        emit(r_type(0, 1, 11, 1, 12));
        store_result(11);
        emit(r_type(0, 5, 13, 3, 12));
        store_result(13);
        emit(r_type(0, 5, 15, 2, 14));
        store_result(15);
        emit(i_type(rv_pkg::OPC_OP_IMM, 1, 16, 1, 17));
        store_result(16);
        emit(i_type(rv_pkg::OPC_OP_IMM, 5, 17, 2, 28));
        store_result(17);
        emit(i_type(rv_pkg::OPC_OP_IMM, 2, 18, 2, -1));
        store_result(18);
        emit(i_type(rv_pkg::OPC_OP_IMM, 7, 19, 2, 'h0f0));
        store_result(19);
        emit(i_type(rv_pkg::OPC_OP_IMM, 6, 20, 1, -256));
        store_result(20);
        emit(i_type(rv_pkg::OPC_OP_IMM, 4, 21, 2, 'h555));
        store_result(21);
        // Distance three, read while x22 retires
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 22, 0, 77));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 23, 0, 1));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 24, 0, 2));
        store_result(22);
        // Load-use into an ALU op and into store data
        emit(i_type(rv_pkg::OPC_LOAD, 2, 25, 0, 'h100));
        emit(r_type(0, 0, 26, 25, 25));
        store_result(26);
        emit(i_type(rv_pkg::OPC_LOAD, 2, 27, 0, 'h104));
        store_result(27);
        // Taken branches skip over writes and a store
        emit(b_type(0, 1, 1, 8));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 28, 0, 'h7ff));
        emit(b_type(1, 1, 1, 8));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 28, 0, 5));
        store_result(28);
        emit(b_type(1, 1, 2, 12));
        emit(s_type(1, 0, 'h3f0));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 28, 0, 9));
        emit(b_type(0, 1, 2, 8));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 28, 28, 1));
        store_result(28);
        // Countdown loop, backward bne
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 29, 0, 3));
        emit(i_type(rv_pkg::OPC_OP_IMM, 0, 29, 29, -1));
        store_result(29);
        emit(b_type(1, 29, 0, -8));
        emit(s_type(1, 0, SENTINEL));
        emit(b_type(0, 0, 0, 0));
    endtask

    // ISA model, fills the expected store list and returns the instruction count
    function automatic int run_model();
        logic [31:0] x [32];
        logic [31:0] mem [256];
        logic [31:0] pc, pc_next, ins, a, b, res, imm_i, imm_s, imm_b;
        logic [2:0]  f3;
        logic        done;
        int          n;
        for (int i = 0; i < 32; i++) begin
            x[i[4:0]] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]] = 32'd0;
        end
        exp_addr.delete();
        exp_data.delete();
        pc = RESET_PC;
        n = 0;
        done = 1'b0;
        while (!done && n < 1000) begin
            ins = imem[pc[8:2]];
            f3 = ins[14:12];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            pc_next = pc + 32'd4;
            n++;
            if (ins[6:0] == rv_pkg::OPC_OP_IMM) begin
                b = imm_i;
            end
            case (ins[6:0])
                rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                    case (f3)
                        3'b000: res = (ins[6:0] == rv_pkg::OPC_OP && ins[30]) ? a - b : a + b;
                        3'b001: res = a << b[4:0];
                        3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100: res = a ^ b;
                        3'b101: res = a >> b[4:0];
                        3'b110: res = a | b;
                        default: res = a & b;
                    endcase
                    x[ins[11:7]] = res;
                end
                rv_pkg::OPC_LUI: x[ins[11:7]] = {ins[31:12], 12'd0};
                rv_pkg::OPC_LOAD: begin
                    res = a + imm_i;
                    x[ins[11:7]] = mem[res[9:2]];
                end
                rv_pkg::OPC_STORE: begin
                    res = a + imm_s;
                    mem[res[9:2]] = b;
                    exp_addr.push_back(res);
                    exp_data.push_back(b);
                end
                rv_pkg::OPC_BRANCH: begin
                    if (f3[0] ? a != b : a == b) begin
                        done = imm_b == 32'd0;
                        pc_next = pc + imm_b;
                    end
                end
                default: ;
            endcase
            x[0] = 32'd0;
            pc = pc_next;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    function automatic int draw_wait();
        if (random_waits) begin
            return int'($urandom % 32'd4);
        end
        return 0;
    endfunction

    // Fetch acknowledge, a fresh delay after every acknowledged cycle
    always @(posedge clk) begin
        if (!arst_n) begin
            acki_n <= 1'b0;
            i_wait <= 0;
        end else if (!acki_n) begin
            i_draw = draw_wait();
            i_wait <= i_draw;
            acki_n <= i_draw != 0;
        end else begin
            i_wait <= i_wait - 1;
            acki_n <= i_wait > 1;
        end
    end

    // Data acknowledge, counts down only while a request is pending
    always @(posedge clk) begin
        if (!arst_n) begin
            ackd_n <= 1'b0;
            d_wait <= 0;
        end else if (mreq && !ackd_n) begin
            d_draw = draw_wait();
            d_wait <= d_draw;
            ackd_n <= d_draw != 0;
        end else if (mreq) begin
            d_wait <= d_wait - 1;
            ackd_n <= d_wait > 1;
        end
    end

    // Data memory and store compare
    always @(posedge clk) begin
        if (!arst_n) begin
            if (in_reset) begin
                check_value("iad", iad, RESET_PC);
                check_value("mreq", 32'(mreq), 32'd0);
            end
            in_reset <= 1'b1;
            cycles <= 0;
            store_idx <= 0;
            held_valid <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                dmem[i[7:0]] <= 32'd0;
            end
        end else begin
            in_reset <= 1'b0;
            cycles <= cycles + 1;
            if (cycles == 0) begin
                check_value("iad", iad, RESET_PC);
            end
            if (cycles < 3 && mreq) begin
                bus_errors++;
                $display("memory request raised before any instruction reached MEM");
            end
            if (held_valid && mreq) begin
                check_value("dad", dad, held_dad);
                check_value("dout", dout, held_dout);
                check_value("write", 32'(write), 32'(held_write));
            end
            held_valid <= mreq && ackd_n;
            held_dad <= dad;
            held_dout <= dout;
            held_write <= write;
            if (mreq && write && !ackd_n) begin
                dmem[dad[9:2]] <= dout;
                if (store_idx < exp_addr.size()) begin
                    check_value("dad", dad, exp_addr[store_idx]);
                    check_value("dout", dout, exp_data[store_idx]);
                end else begin
                    bus_errors++;
                    $display("unexpected store to address %08h after the last one", dad);
                end
                store_idx <= store_idx + 1;
            end
        end
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        acki_n = 1'b0;
        ackd_n = 1'b0;
        void'($urandom(32'h5d28_d39c));
        load_program();
        exp_count = run_model();
        if (exp_addr.size() == 0 || exp_addr[$] != SENTINEL) begin
            run_errors++;
            stop_run = 1'b1;
            $display("reference model never reached the sentinel store");
        end
        // Five stages plus the longest wait per instruction
        limit = exp_count * 8 + 50;
        // First pass without waits, second with random waits on both memories
        for (int pass = 0; pass < 2 && !stop_run; pass++) begin
            random_waits = pass == 1;
            @(posedge clk);
            arst_n <= 1'b0;
            repeat (2) @(posedge clk);
            arst_n <= 1'b1;
            @(negedge clk);
            while (store_idx < exp_addr.size() && cycles < limit) begin
                @(negedge clk);
            end
            if (store_idx < exp_addr.size()) begin
                run_errors++;
                stop_run = 1'b1;
                $display("run timed out after %0d cycles in pass %0d", cycles, pass);
            end
        end
        $display("errors: %0d mismatches, %0d bus errors, %0d run errors",
                 mismatches, bus_errors, run_errors);
        if (mismatches == 0 && bus_errors == 0 && run_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: list.f
hw/rv_pkg.sv
hw/pipe_reg.sv
hw/regfile.sv
hw/decoder.sv
hw/alu.sv
hw/hazard_unit.sv
hw/core_top.sv
sim/core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/core_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
